// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_TEXT ?= TEST OK
SOURCES   := $(wildcard logic/*.sv bench/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# status comes from the pass line, not from the simulator exit code
sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/core_chk.sv ====
`timescale 1ns/1ns

module core_chk (
  input logic        i_clk,
  input logic        i_rst,
  input logic [31:0] i_imem_addr,
  input logic [31:0] i_dmem_addr,
  input logic        i_dmem_we
);

  // memory stage register is a bubble once reset has been seen
  a_no_store_in_reset: assert property (
    @(posedge i_clk) i_rst |=> !i_dmem_we
  ) else $error("data write enable high right after a reset cycle");

  a_fetch_aligned: assert property (
    @(posedge i_clk) disable iff (i_rst) i_imem_addr[1:0] == 2'b00
  ) else $error("fetch address 0x%08h not word aligned", i_imem_addr);

  // only sw exists, so every store is a word store
  a_store_aligned: assert property (
    @(posedge i_clk) disable iff (i_rst) i_dmem_we |-> i_dmem_addr[1:0] == 2'b00
  ) else $error("store address 0x%08h not word aligned", i_dmem_addr);

endmodule

bind pipeline_core core_chk u_core_chk (
  .i_clk(i_clk),
  .i_rst(i_rst),
  .i_imem_addr(o_imem_addr),
  .i_dmem_addr(o_dmem_addr),
  .i_dmem_we(o_dmem_we)
);

// ==== bench/core_tb.sv ====
`timescale 1ns/1ns

module core_tb;

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 3;
  localparam int BUDGET       = 40;
  localparam int MARGIN_NS    = 400;
  localparam int IMEM_WORDS   = 256;
  localparam int DMEM_WORDS   = 256;
  localparam logic [31:0] LFSR_SEED = 32'd39;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  // byte offsets in data memory
  localparam logic [11:0] RES_BASE = 12'h200;
  localparam logic [11:0] MARK_OFF = 12'h300;
  localparam logic [11:0] LOAD_OFF = 12'h380;

  // rv32i opcodes
  localparam logic [6:0] OPC_R      = 7'b0110011;
  localparam logic [6:0] OPC_IMM    = 7'b0010011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  localparam logic DRAW  = 1'b1;
  localparam logic FIXED = 1'b0;

  typedef enum logic [4:0] {
    K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_SLT, K_SLTU,
    K_ADDI, K_ANDI, K_ORI, K_XORI, K_SLTI,
    K_CHAIN, K_LOAD_USE, K_BEQ, K_BNE, K_JAL, K_ZERO, K_CONST
  } t_kind;

  typedef struct packed {
    t_kind       kind;
    logic        a_draw;
    logic [31:0] a_val;
    logic        b_draw;
    logic [31:0] b_val;
  } t_test;

  logic        clk = 1'b0;
  logic        rst;
  logic [31:0] imem_addr;
  logic [31:0] imem_data;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_wdata;
  logic        dmem_we;
  logic [31:0] dmem_rdata;

  logic [31:0] imem    [IMEM_WORDS];
  logic [31:0] dmem    [DMEM_WORDS];
  logic [31:0] ref_mem [DMEM_WORDS];
  t_test       tests   [32];
  int          n_tests = 0;
  int          pc_idx;
  int          pass_count = 0;
  int          fail_count = 0;
  logic [31:0] lfsr;

  always #(CLK_PERIOD / 2) clk = ~clk;

  pipeline_core dut (
    .i_clk(clk), .i_rst(rst),
    .o_imem_addr(imem_addr), .i_imem_data(imem_data),
    .o_dmem_addr(dmem_addr), .o_dmem_wdata(dmem_wdata),
    .o_dmem_we(dmem_we), .i_dmem_rdata(dmem_rdata)
  );

  assign imem_data  = imem[imem_addr[9:2]];
  assign dmem_rdata = dmem[dmem_addr[9:2]];

  // memory refilled on every reset cycle
  always @(posedge clk) begin
    int w;
    if (rst) begin
      for (w = 0; w < DMEM_WORDS; w++) begin
        dmem[w[7:0]] <= fill_word(w);
      end
    end else if (dmem_we) begin
      dmem[dmem_addr[9:2]] <= dmem_wdata;
    end
  end

  function automatic logic [31:0] fill_word(input int w);
    logic [31:0] addr;
    addr = 32'(w) << 2;
    return (addr * 32'h9E37_79B1) ^ 32'hC3C3_3C3C;
  endfunction

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  // one lfsr step per bit
  task automatic draw_word(output logic [31:0] w);
    int i;
    w = 32'd0;
    for (i = 0; i < 32; i++) begin
      w = {w[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, OPC_R};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  // sw src, off(x0)
  function automatic logic [31:0] store_word(input logic [11:0] off, input logic [4:0] src);
    return {off[11:5], src, 5'd0, 3'b010, off[4:0], OPC_STORE};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
  endfunction

  // x3 = x1 op x2, or x3 = x1 op imm
  function automatic logic [31:0] alu_instr(input t_kind kind, input logic [11:0] imm);
    logic [31:0] w;
    case (kind)
      K_ADD:   w = r_type(7'h00, 3'b000, 5'd3, 5'd1, 5'd2);
      K_SUB:   w = r_type(7'h20, 3'b000, 5'd3, 5'd1, 5'd2);
      K_AND:   w = r_type(7'h00, 3'b111, 5'd3, 5'd1, 5'd2);
      K_OR:    w = r_type(7'h00, 3'b110, 5'd3, 5'd1, 5'd2);
      K_XOR:   w = r_type(7'h00, 3'b100, 5'd3, 5'd1, 5'd2);
      K_SLT:   w = r_type(7'h00, 3'b010, 5'd3, 5'd1, 5'd2);
      K_SLTU:  w = r_type(7'h00, 3'b011, 5'd3, 5'd1, 5'd2);
      K_ADDI:  w = i_type(imm, 5'd1, 3'b000, 5'd3, OPC_IMM);
      K_ANDI:  w = i_type(imm, 5'd1, 3'b111, 5'd3, OPC_IMM);
      K_ORI:   w = i_type(imm, 5'd1, 3'b110, 5'd3, OPC_IMM);
      K_XORI:  w = i_type(imm, 5'd1, 3'b100, 5'd3, OPC_IMM);
      K_SLTI:  w = i_type(imm, 5'd1, 3'b010, 5'd3, OPC_IMM);
      default: w = 32'd0;
    endcase
    return w;
  endfunction

  function automatic logic [31:0] model_alu(input t_kind kind, input logic [31:0] a,
                                            input logic [31:0] b);
    logic [31:0] imm;
    logic [31:0] y;
    imm = {{20{b[11]}}, b[11:0]};
    case (kind)
      K_ADD:   y = a + b;
      K_SUB:   y = a - b;
      K_AND:   y = a & b;
      K_OR:    y = a | b;
      K_XOR:   y = a ^ b;
      K_SLT:   y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      K_SLTU:  y = (a < b) ? 32'd1 : 32'd0;
      K_ADDI:  y = a + imm;
      K_ANDI:  y = a & imm;
      K_ORI:   y = a | imm;
      K_XORI:  y = a ^ imm;
      K_SLTI:  y = ($signed(a) < $signed(imm)) ? 32'd1 : 32'd0;
      default: y = 32'd0;
    endcase
    return y;
  endfunction

  task automatic emit(input logic [31:0] w);
    imem[pc_idx[7:0]] = w;
    pc_idx = pc_idx + 1;
  endtask

  task automatic expect_word(input logic [11:0] off, input logic [31:0] val);
    ref_mem[off[9:2]] = val;
  endtask

  // lui then addi, upper part rounded for the signed low half
  task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
    logic [31:0] upper;
    upper = (v + 32'h0000_0800) >> 12;
    emit({upper[19:0], rd, OPC_LUI});
    emit(i_type(v[11:0], rd, 3'b000, rd, OPC_IMM));
  endtask

  task automatic build_program(input t_kind kind, input logic [31:0] a,
                               input logic [31:0] b, input int idx);
    logic [11:0] res_off;
    logic        taken;
    int          jal_pc;
    int          w;
    for (w = 0; w < IMEM_WORDS; w++) begin
      imem[w[7:0]] = i_type(12'h000, 5'd0, 3'b000, 5'd0, OPC_IMM);
    end
    for (w = 0; w < DMEM_WORDS; w++) begin
      ref_mem[w[7:0]] = fill_word(w);
    end
    res_off = RES_BASE + 12'(idx * 4);
    pc_idx = 0;
    load_const(5'd1, a);
    load_const(5'd2, b);
    case (kind)
      // mem and wb forwarding with no gaps
      K_CHAIN: begin
        emit(r_type(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
        emit(r_type(7'h00, 3'b100, 5'd4, 5'd1, 5'd2));
        emit(r_type(7'h00, 3'b110, 5'd5, 5'd3, 5'd4));
        emit(r_type(7'h20, 3'b000, 5'd3, 5'd5, 5'd3));
        emit(store_word(res_off, 5'd3));
        expect_word(res_off, ((a + b) | (a ^ b)) - (a + b));
      end
      K_LOAD_USE: begin
        emit(store_word(LOAD_OFF, 5'd1));
        emit(i_type(LOAD_OFF, 5'd0, 3'b010, 5'd4, OPC_LOAD));
        emit(r_type(7'h00, 3'b000, 5'd3, 5'd4, 5'd2));
        emit(store_word(res_off, 5'd3));
        expect_word(LOAD_OFF, a);
        expect_word(res_off, a + b);
      end
      // two marker stores sit in the shadow of the branch
      K_BEQ, K_BNE: begin
        taken = (kind == K_BEQ) ? (a == b) : (a != b);
        emit(b_type(13'd12, 5'd1, 5'd2, (kind == K_BNE) ? 3'b001 : 3'b000));
        emit(store_word(MARK_OFF, 5'd1));
        emit(store_word(MARK_OFF + 12'd4, 5'd2));
        emit(i_type(12'h05A, 5'd0, 3'b000, 5'd3, OPC_IMM));
        emit(store_word(res_off, 5'd3));
        if (!taken) begin
          expect_word(MARK_OFF, a);
          expect_word(MARK_OFF + 12'd4, b);
        end
        expect_word(res_off, 32'h0000_005A);
      end
      K_JAL: begin
        jal_pc = pc_idx * 4;
        emit(j_type(21'd12, 5'd5));
        emit(store_word(MARK_OFF, 5'd1));
        emit(store_word(MARK_OFF + 12'd4, 5'd2));
        emit(store_word(res_off, 5'd5));
        expect_word(res_off, 32'(jal_pc + 4));
      end
      // write to x0 must be dropped
      K_ZERO: begin
        emit(i_type(12'h000, 5'd1, 3'b000, 5'd0, OPC_IMM));
        emit(store_word(res_off, 5'd0));
        expect_word(res_off, 32'd0);
      end
      K_CONST: begin
        emit(store_word(res_off, 5'd1));
        expect_word(res_off, a);
      end
      default: begin
        emit(alu_instr(kind, b[11:0]));
        emit(store_word(res_off, 5'd3));
        expect_word(res_off, model_alu(kind, a, b));
      end
    endcase
    // park on jal x0, 0
    emit(j_type(21'd0, 5'd0));
  endtask

  task automatic compare_mem(output int errs);
    int w;
    errs = 0;
    for (w = 0; w < DMEM_WORDS; w++) begin
      if (dmem[w[7:0]] !== ref_mem[w[7:0]]) begin
        $display("mismatch at %0t ns: dmem[0x%03h] got 0x%08h expected 0x%08h",
                 $time, w * 4, dmem[w[7:0]], ref_mem[w[7:0]]);
        errs++;
      end
    end
  endtask

  task automatic add_test(input t_kind kind, input logic a_draw, input logic [31:0] a_val,
                          input logic b_draw, input logic [31:0] b_val);
    tests[n_tests[4:0]] = '{kind, a_draw, a_val, b_draw, b_val};
    n_tests = n_tests + 1;
  endtask

  task automatic fill_table();
    add_test(K_ADD,      FIXED, 32'd5,         FIXED, 32'd7);
    add_test(K_ADD,      DRAW,  32'd0,         DRAW,  32'd0);
    add_test(K_SUB,      FIXED, 32'd0,         FIXED, 32'd1);
    add_test(K_SUB,      DRAW,  32'd0,         DRAW,  32'd0);
    add_test(K_AND,      DRAW,  32'd0,         DRAW,  32'd0);
    add_test(K_OR,       DRAW,  32'd0,         DRAW,  32'd0);
    add_test(K_XOR,      DRAW,  32'd0,         DRAW,  32'd0);
    add_test(K_SLT,      FIXED, 32'h8000_0000, FIXED, 32'h7FFF_FFFF);
    add_test(K_SLT,      DRAW,  32'd0,         DRAW,  32'd0);
    add_test(K_SLTU,     FIXED, 32'h8000_0000, FIXED, 32'h7FFF_FFFF);
    add_test(K_SLTU,     DRAW,  32'd0,         DRAW,  32'd0);
    add_test(K_ADDI,     DRAW,  32'd0,         FIXED, 32'h0000_0FFF);
    add_test(K_ANDI,     DRAW,  32'd0,         DRAW,  32'd0);
    add_test(K_ORI,      DRAW,  32'd0,         DRAW,  32'd0);
    add_test(K_XORI,     DRAW,  32'd0,         DRAW,  32'd0);
    add_test(K_SLTI,     FIXED, 32'hFFFF_FFFE, FIXED, 32'h0000_07FF);
    add_test(K_CHAIN,    DRAW,  32'd0,         DRAW,  32'd0);
    add_test(K_LOAD_USE, DRAW,  32'd0,         DRAW,  32'd0);
    add_test(K_BEQ,      FIXED, 32'd9,         FIXED, 32'd9);
    add_test(K_BEQ,      FIXED, 32'd9,         FIXED, 32'd10);
    add_test(K_BNE,      DRAW,  32'd0,         DRAW,  32'd0);
    add_test(K_BNE,      FIXED, 32'd3,         FIXED, 32'd3);
    add_test(K_JAL,      DRAW,  32'd0,         DRAW,  32'd0);
    add_test(K_ZERO,     DRAW,  32'd0,         DRAW,  32'd0);
    add_test(K_CONST,    FIXED, 32'h7FFF_FFFF, FIXED, 32'hFFFF_F800);
    add_test(K_CONST,    FIXED, 32'hFFFF_F800, FIXED, 32'h0000_0800);
  endtask

  initial begin
    int          idx;
    int          errs;
    logic [31:0] a;
    logic [31:0] b;
    t_kind       kind;
    lfsr = LFSR_SEED;
    rst = 1'b1;
    fill_table();
    for (idx = 0; idx < n_tests; idx++) begin
      kind = tests[idx[4:0]].kind;
      a = tests[idx[4:0]].a_val;
      b = tests[idx[4:0]].b_val;
      if (tests[idx[4:0]].a_draw) begin
        draw_word(a);
      end
      if (tests[idx[4:0]].b_draw) begin
        draw_word(b);
      end
      rst = 1'b1;
      build_program(kind, a, b, idx);
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      rst = 1'b0;
      repeat (BUDGET) @(posedge clk);
      #1;
      compare_mem(errs);
      if (errs == 0) begin
        pass_count++;
        $display("test %0d %s a=%h b=%h: pass", idx, kind.name(), a, b);
      end else begin
        fail_count++;
        $display("test %0d %s a=%h b=%h: fail, %0d words wrong", idx, kind.name(), a, b, errs);
      end
    end
    $display("%0d tests, %0d passed, %0d failed", n_tests, pass_count, fail_count);
    if (fail_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // limit from table length, table is filled at time zero
  initial begin
    #1;
    #(n_tests * (BUDGET + RESET_CYCLES) * CLK_PERIOD + MARGIN_NS);
    $display("timeout: the tests did not finish in the expected time");
    $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== logic/alu.sv ====
`timescale 1ns/1ns

module alu import rv_pkg::*; (
  input  t_alu_op     i_op,
  input  logic [31:0] i_a,
  input  logic [31:0] i_b,
  output logic [31:0] o_y,
  output logic        o_zero
);

  always_comb begin
    case (i_op)
      ALU_ADD: begin
        o_y = i_a + i_b;
      end
      // also the compare for beq and bne
      ALU_SUB: begin
        o_y = i_a - i_b;
      end
      ALU_AND: begin
        o_y = i_a & i_b;
      end
      ALU_OR: begin
        o_y = i_a | i_b;
      end
      ALU_XOR: begin
        o_y = i_a ^ i_b;
      end
      ALU_SLT: begin
        o_y = {31'd0, $signed(i_a) < $signed(i_b)};
      end
      ALU_SLTU: begin
        o_y = {31'd0, i_a < i_b};
      end
      // lui immediate straight through
      default: begin
        o_y = i_b;
      end
    endcase
  end

  assign o_zero = (o_y == 32'd0);

endmodule

// ==== logic/controller.sv ====
`timescale 1ns/1ns

module controller import rv_pkg::*; (
  input  logic [31:0] i_instr,
  output t_ctrl       o_ctrl
);

  t_opcode    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = t_opcode'(i_instr[6:0]);
  assign funct3 = i_instr[14:12];
  assign funct7 = i_instr[31:25];

  // anything not recognised falls back to all-zero control
  always_comb begin
    o_ctrl = '0;
    case (opcode)
      OP_R: begin
        o_ctrl.reg_write = 1'b1;
        case ({funct7, funct3})
          {7'h00, 3'b000}: o_ctrl.alu_op = ALU_ADD;
          {7'h20, 3'b000}: o_ctrl.alu_op = ALU_SUB;
          {7'h00, 3'b111}: o_ctrl.alu_op = ALU_AND;
          {7'h00, 3'b110}: o_ctrl.alu_op = ALU_OR;
          {7'h00, 3'b100}: o_ctrl.alu_op = ALU_XOR;
          {7'h00, 3'b010}: o_ctrl.alu_op = ALU_SLT;
          {7'h00, 3'b011}: o_ctrl.alu_op = ALU_SLTU;
          default:         o_ctrl = '0;
        endcase
      end
      OP_IMM: begin
        o_ctrl.reg_write = 1'b1;
        o_ctrl.alu_src   = 1'b1;
        o_ctrl.imm_src   = IMM_I;
        case (funct3)
          3'b000:  o_ctrl.alu_op = ALU_ADD;
          3'b111:  o_ctrl.alu_op = ALU_AND;
          3'b110:  o_ctrl.alu_op = ALU_OR;
          3'b100:  o_ctrl.alu_op = ALU_XOR;
          3'b010:  o_ctrl.alu_op = ALU_SLT;
          // sltiu and shifts are not supported
          default: o_ctrl = '0;
        endcase
      end
      // word access only
      OP_LOAD: begin
        if (funct3 == 3'b010) begin
          o_ctrl.reg_write  = 1'b1;
          o_ctrl.result_src = RES_MEM;
          o_ctrl.alu_src    = 1'b1;
          o_ctrl.imm_src    = IMM_I;
        end
      end
      OP_STORE: begin
        if (funct3 == 3'b010) begin
          o_ctrl.mem_write = 1'b1;
          o_ctrl.alu_src   = 1'b1;
          o_ctrl.imm_src   = IMM_S;
        end
      end
      OP_BRANCH: begin
        if (funct3 == 3'b000 || funct3 == 3'b001) begin
          o_ctrl.branch    = 1'b1;
          o_ctrl.branch_ne = funct3[0];
          o_ctrl.alu_op    = ALU_SUB;
          o_ctrl.imm_src   = IMM_B;
        end
      end
      OP_JAL: begin
        o_ctrl.reg_write  = 1'b1;
        o_ctrl.result_src = RES_PC4;
        o_ctrl.jump       = 1'b1;
        o_ctrl.imm_src    = IMM_J;
      end
      OP_LUI: begin
        o_ctrl.reg_write = 1'b1;
        o_ctrl.alu_src   = 1'b1;
        o_ctrl.alu_op    = ALU_PASS_B;
        o_ctrl.imm_src   = IMM_U;
      end
      default: begin
        o_ctrl = '0;
      end
    endcase
  end

endmodule

// ==== logic/datapath.sv ====
`timescale 1ns/1ns

module datapath import rv_pkg::*; #(
  parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
  input  logic        i_clk,
  input  logic        i_rst,
  input  logic [31:0] i_imem_data,
  input  logic [31:0] i_dmem_rdata,
  input  t_ctrl       i_ctrl_d,
  input  logic        i_stall_f,
  input  logic        i_stall_d,
  input  logic        i_flush_d,
  input  logic        i_flush_e,
  input  t_fwd_sel    i_fwd_a,
  input  t_fwd_sel    i_fwd_b,
  output logic [31:0] o_imem_addr,
  output logic [31:0] o_dmem_addr,
  output logic [31:0] o_dmem_wdata,
  output logic        o_dmem_we,
  output logic [31:0] o_instr_d,
  output logic [4:0]  o_rs1_d,
  output logic [4:0]  o_rs2_d,
  output logic [4:0]  o_rs1_e,
  output logic [4:0]  o_rs2_e,
  output logic [4:0]  o_rd_e,
  output logic        o_load_e,
  output logic [4:0]  o_rd_m,
  output logic        o_reg_write_m,
  output logic [4:0]  o_rd_w,
  output logic        o_reg_write_w,
  output logic        o_redirect_e
);

  localparam t_if_id IF_ID_BUBBLE = '{instr: NOP_INSTR, default: '0};

  logic [31:0] pc_f;
  logic [31:0] pc_plus4_f;
  t_if_id      if_id_d;
  t_if_id      if_id_q;
  logic [31:0] rd1_d;
  logic [31:0] rd2_d;
  logic [31:0] imm_d;
  t_id_ex      id_ex_d;
  t_id_ex      id_ex_q;
  logic [31:0] src_a_e;
  logic [31:0] fwd_b_e;
  logic [31:0] src_b_e;
  logic [31:0] alu_y_e;
  logic        zero_e;
  logic [31:0] target_e;
  t_ex_mem     ex_mem_d;
  t_ex_mem     ex_mem_q;
  logic [31:0] result_m;
  t_mem_wb     mem_wb_d;
  t_mem_wb     mem_wb_q;
  logic [31:0] result_w;

  function automatic logic [31:0] fwd_mux(input t_fwd_sel sel, input logic [31:0] reg_val);
    logic [31:0] val;
    case (sel)
      FWD_MEM: val = result_m;
      FWD_WB:  val = result_w;
      default: val = reg_val;
    endcase
    return val;
  endfunction

  // fetch, redirect beats the load-use hold
  assign pc_plus4_f = pc_f + 32'd4;
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pc_f <= RESET_PC;
    end else if (o_redirect_e) begin
      pc_f <= target_e;
    end else if (!i_stall_f) begin
      pc_f <= pc_plus4_f;
    end
  end
  assign o_imem_addr = pc_f;
  assign if_id_d = '{instr: i_imem_data, pc: pc_f, pc_plus4: pc_plus4_f};

  pipe_reg #(.T_DATA(t_if_id), .RESET_VALUE(IF_ID_BUBBLE)) u_if_id (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_enable(~i_stall_d), .i_clear(i_flush_d),
    .i_d(if_id_d), .o_q(if_id_q)
  );

  // decode
  assign o_instr_d = if_id_q.instr;
  assign o_rs1_d   = if_id_q.instr[19:15];
  assign o_rs2_d   = if_id_q.instr[24:20];

  reg_file u_reg_file (
    .i_clk(i_clk), .i_we(mem_wb_q.ctrl.reg_write),
    .i_rs1(o_rs1_d), .i_rs2(o_rs2_d),
    .i_rd(mem_wb_q.rd), .i_wdata(result_w),
    .o_rd1(rd1_d), .o_rd2(rd2_d)
  );

  imm_extend u_imm_extend (
    .i_instr(if_id_q.instr), .i_imm_src(i_ctrl_d.imm_src), .o_imm(imm_d)
  );

  assign id_ex_d = '{ctrl: i_ctrl_d, rd1: rd1_d, rd2: rd2_d, imm: imm_d,
                     pc: if_id_q.pc, pc_plus4: if_id_q.pc_plus4,
                     rs1: o_rs1_d, rs2: o_rs2_d, rd: if_id_q.instr[11:7]};

  pipe_reg #(.T_DATA(t_id_ex), .RESET_VALUE('0)) u_id_ex (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_enable(1'b1), .i_clear(i_flush_e),
    .i_d(id_ex_d), .o_q(id_ex_q)
  );

  // execute
  assign src_a_e = fwd_mux(i_fwd_a, id_ex_q.rd1);
  assign fwd_b_e = fwd_mux(i_fwd_b, id_ex_q.rd2);
  assign src_b_e = id_ex_q.ctrl.alu_src ? id_ex_q.imm : fwd_b_e;

  alu u_alu (
    .i_op(id_ex_q.ctrl.alu_op), .i_a(src_a_e), .i_b(src_b_e),
    .o_y(alu_y_e), .o_zero(zero_e)
  );

  // beq taken on zero, bne on nonzero
  assign target_e     = id_ex_q.pc + id_ex_q.imm;
  assign o_redirect_e = id_ex_q.ctrl.jump |
                        (id_ex_q.ctrl.branch & (zero_e ^ id_ex_q.ctrl.branch_ne));
  assign o_rs1_e  = id_ex_q.rs1;
  assign o_rs2_e  = id_ex_q.rs2;
  assign o_rd_e   = id_ex_q.rd;
  assign o_load_e = (id_ex_q.ctrl.result_src == RES_MEM);

  assign ex_mem_d = '{ctrl: id_ex_q.ctrl, alu_out: alu_y_e, write_data: fwd_b_e,
                      pc_plus4: id_ex_q.pc_plus4, rd: id_ex_q.rd};

  pipe_reg #(.T_DATA(t_ex_mem), .RESET_VALUE('0)) u_ex_mem (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_enable(1'b1), .i_clear(1'b0),
    .i_d(ex_mem_d), .o_q(ex_mem_q)
  );

  // memory
  assign o_dmem_addr   = ex_mem_q.alu_out;
  assign o_dmem_wdata  = ex_mem_q.write_data;
  assign o_dmem_we     = ex_mem_q.ctrl.mem_write;
  assign o_rd_m        = ex_mem_q.rd;
  assign o_reg_write_m = ex_mem_q.ctrl.reg_write;
  // jal link value has to be forwarded too
  assign result_m = (ex_mem_q.ctrl.result_src == RES_PC4) ? ex_mem_q.pc_plus4
                                                          : ex_mem_q.alu_out;

  assign mem_wb_d = '{ctrl: ex_mem_q.ctrl, alu_out: ex_mem_q.alu_out,
                      read_data: i_dmem_rdata, pc_plus4: ex_mem_q.pc_plus4,
                      rd: ex_mem_q.rd};

  pipe_reg #(.T_DATA(t_mem_wb), .RESET_VALUE('0)) u_mem_wb (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_enable(1'b1), .i_clear(1'b0),
    .i_d(mem_wb_d), .o_q(mem_wb_q)
  );

  // write-back
  always_comb begin
    case (mem_wb_q.ctrl.result_src)
      RES_MEM: result_w = mem_wb_q.read_data;
      RES_PC4: result_w = mem_wb_q.pc_plus4;
      default: result_w = mem_wb_q.alu_out;
    endcase
  end
  assign o_rd_w        = mem_wb_q.rd;
  assign o_reg_write_w = mem_wb_q.ctrl.reg_write;

endmodule

// ==== logic/hazard_unit.sv ====
`timescale 1ns/1ns

module hazard_unit import rv_pkg::*; (
  input  logic [4:0] i_rs1_d,
  input  logic [4:0] i_rs2_d,
  input  logic [4:0] i_rs1_e,
  input  logic [4:0] i_rs2_e,
  input  logic [4:0] i_rd_e,
  input  logic       i_load_e,
  input  logic [4:0] i_rd_m,
  input  logic       i_reg_write_m,
  input  logic [4:0] i_rd_w,
  input  logic       i_reg_write_w,
  input  logic       i_redirect_e,
  output logic       o_stall_f,
  output logic       o_stall_d,
  output logic       o_flush_d,
  output logic       o_flush_e,
  output t_fwd_sel   o_fwd_a,
  output t_fwd_sel   o_fwd_b
);

  logic load_use;

  // memory stage is younger, so it wins
  function automatic t_fwd_sel fwd_pick(input logic [4:0] rs);
    t_fwd_sel sel;
    if (rs != 5'd0 && rs == i_rd_m && i_reg_write_m) begin
      sel = FWD_MEM;
    end else if (rs != 5'd0 && rs == i_rd_w && i_reg_write_w) begin
      sel = FWD_WB;
    end else begin
      sel = FWD_REG;
    end
    return sel;
  endfunction

  assign o_fwd_a = fwd_pick(i_rs1_e);
  assign o_fwd_b = fwd_pick(i_rs2_e);

  // load result not ready until write-back
  assign load_use = i_load_e && (i_rd_e != 5'd0) &&
                    ((i_rd_e == i_rs1_d) || (i_rd_e == i_rs2_d));

  assign o_stall_f = load_use;
  assign o_stall_d = load_use;
  assign o_flush_d = i_redirect_e;
  assign o_flush_e = load_use | i_redirect_e;

endmodule

// ==== logic/imm_extend.sv ====
`timescale 1ns/1ns

module imm_extend import rv_pkg::*; (
  input  logic [31:0] i_instr,
  input  t_imm_src    i_imm_src,
  output logic [31:0] o_imm
);

  logic sign;

  assign sign = i_instr[31];

  always_comb begin
    case (i_imm_src)
      IMM_I: begin
        o_imm = {{20{sign}}, i_instr[31:20]};
      end
      IMM_S: begin
        o_imm = {{20{sign}}, i_instr[31:25], i_instr[11:7]};
      end
      // branch offset, bit 0 always zero
      IMM_B: begin
        o_imm = {{20{sign}}, i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0};
      end
      IMM_U: begin
        o_imm = {i_instr[31:12], 12'd0};
      end
      // jal offset
      IMM_J: begin
        o_imm = {{12{sign}}, i_instr[19:12], i_instr[20], i_instr[30:21], 1'b0};
      end
      default: begin
        o_imm = 32'd0;
      end
    endcase
  end

endmodule

// ==== logic/pipe_reg.sv ====
`timescale 1ns/1ns

module pipe_reg #(
  parameter type T_DATA = logic [31:0],
  parameter T_DATA RESET_VALUE = '0
) (
  input  logic  i_clk,
  input  logic  i_rst,
  input  logic  i_enable,
  input  logic  i_clear,
  input  T_DATA i_d,
  output T_DATA o_q
);

  // clear turns the stage into a bubble
  always_ff @(posedge i_clk) begin
    if (i_rst || i_clear) begin
      o_q <= RESET_VALUE;
    end else if (i_enable) begin
      o_q <= i_d;
    end
  end

endmodule

// ==== logic/pipeline_core.sv ====
`timescale 1ns/1ns

module pipeline_core import rv_pkg::*; #(
  parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
  input  logic        i_clk,
  input  logic        i_rst,
  output logic [31:0] o_imem_addr,
  input  logic [31:0] i_imem_data,
  output logic [31:0] o_dmem_addr,
  output logic [31:0] o_dmem_wdata,
  output logic        o_dmem_we,
  input  logic [31:0] i_dmem_rdata
);

  logic [31:0] instr_d;
  t_ctrl       ctrl_d;
  logic        stall_f;
  logic        stall_d;
  logic        flush_d;
  logic        flush_e;
  t_fwd_sel    fwd_a;
  t_fwd_sel    fwd_b;
  logic [4:0]  rs1_d;
  logic [4:0]  rs2_d;
  logic [4:0]  rs1_e;
  logic [4:0]  rs2_e;
  logic [4:0]  rd_e;
  logic        load_e;
  logic [4:0]  rd_m;
  logic        reg_write_m;
  logic [4:0]  rd_w;
  logic        reg_write_w;
  logic        redirect_e;

  controller u_controller (
    .i_instr(instr_d), .o_ctrl(ctrl_d)
  );

  hazard_unit u_hazard_unit (
    .i_rs1_d(rs1_d), .i_rs2_d(rs2_d),
    .i_rs1_e(rs1_e), .i_rs2_e(rs2_e),
    .i_rd_e(rd_e), .i_load_e(load_e),
    .i_rd_m(rd_m), .i_reg_write_m(reg_write_m),
    .i_rd_w(rd_w), .i_reg_write_w(reg_write_w),
    .i_redirect_e(redirect_e),
    .o_stall_f(stall_f), .o_stall_d(stall_d),
    .o_flush_d(flush_d), .o_flush_e(flush_e),
    .o_fwd_a(fwd_a), .o_fwd_b(fwd_b)
  );

  datapath #(.RESET_PC(RESET_PC)) u_datapath (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_imem_data(i_imem_data), .i_dmem_rdata(i_dmem_rdata),
    .i_ctrl_d(ctrl_d),
    .i_stall_f(stall_f), .i_stall_d(stall_d),
    .i_flush_d(flush_d), .i_flush_e(flush_e),
    .i_fwd_a(fwd_a), .i_fwd_b(fwd_b),
    .o_imem_addr(o_imem_addr),
    .o_dmem_addr(o_dmem_addr), .o_dmem_wdata(o_dmem_wdata),
    .o_dmem_we(o_dmem_we),
    .o_instr_d(instr_d),
    .o_rs1_d(rs1_d), .o_rs2_d(rs2_d),
    .o_rs1_e(rs1_e), .o_rs2_e(rs2_e),
    .o_rd_e(rd_e), .o_load_e(load_e),
    .o_rd_m(rd_m), .o_reg_write_m(reg_write_m),
    .o_rd_w(rd_w), .o_reg_write_w(reg_write_w),
    .o_redirect_e(redirect_e)
  );

endmodule

// ==== logic/reg_file.sv ====
`timescale 1ns/1ns

module reg_file (
  input  logic        i_clk,
  input  logic        i_we,
  input  logic [4:0]  i_rs1,
  input  logic [4:0]  i_rs2,
  input  logic [4:0]  i_rd,
  input  logic [31:0] i_wdata,
  output logic [31:0] o_rd1,
  output logic [31:0] o_rd2
);

  // x0 has no storage
  logic [31:0] regs [1:31];

  function automatic logic [31:0] read_port(input logic [4:0] addr);
    logic [31:0] val;
    if (addr == 5'd0) begin
      val = 32'd0;
    end else if (i_we && (addr == i_rd)) begin
      // write-back value seen in the same cycle
      val = i_wdata;
    end else begin
      val = regs[addr];
    end
    return val;
  endfunction

  always_ff @(posedge i_clk) begin
    if (i_we && (i_rd != 5'd0)) begin
      regs[i_rd] <= i_wdata;
    end
  end

  assign o_rd1 = read_port(i_rs1);
  assign o_rd2 = read_port(i_rs2);

endmodule

// ==== logic/rv_pkg.sv ====
package rv_pkg;

  // base opcodes of the supported subset
  typedef enum logic [6:0] {
    OP_R      = 7'b0110011,
    OP_IMM    = 7'b0010011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_BRANCH = 7'b1100011,
    OP_JAL    = 7'b1101111,
    OP_LUI    = 7'b0110111
  } t_opcode;

  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLTU, ALU_PASS_B
  } t_alu_op;

  typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} t_imm_src;

  // execute operand source
  typedef enum logic [1:0] {FWD_REG, FWD_MEM, FWD_WB} t_fwd_sel;

  typedef enum logic [1:0] {RES_ALU, RES_MEM, RES_PC4} t_result_src;

  // all zero is a bubble
  typedef struct packed {
    logic        reg_write;
    logic        mem_write;
    t_result_src result_src;
    logic        alu_src;
    t_alu_op     alu_op;
    logic        branch;
    logic        branch_ne;
    logic        jump;
    t_imm_src    imm_src;
  } t_ctrl;

  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] pc;
    logic [31:0] pc_plus4;
  } t_if_id;

  typedef struct packed {
    t_ctrl       ctrl;
    logic [31:0] rd1;
    logic [31:0] rd2;
    logic [31:0] imm;
    logic [31:0] pc;
    logic [31:0] pc_plus4;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
  } t_id_ex;

  typedef struct packed {
    t_ctrl       ctrl;
    logic [31:0] alu_out;
    logic [31:0] write_data;
    logic [31:0] pc_plus4;
    logic [4:0]  rd;
  } t_ex_mem;

  typedef struct packed {
    t_ctrl       ctrl;
    logic [31:0] alu_out;
    logic [31:0] read_data;
    logic [31:0] pc_plus4;
    logic [4:0]  rd;
  } t_mem_wb;

  // addi x0, x0, 0
  localparam logic [31:0] NOP_INSTR = 32'h0000_0013;

endpackage

// ==== sim.f ====
logic/rv_pkg.sv
logic/pipe_reg.sv
logic/reg_file.sv
logic/imm_extend.sv
logic/alu.sv
logic/controller.sv
logic/hazard_unit.sv
logic/datapath.sv
logic/pipeline_core.sv
bench/core_chk.sv
bench/core_tb.sv
